// ==== src/cryptPkg.sv ====
// shared types, register map enum and constants of the protection subsystem
package cryptPkg;

    localparam int keyBytes = 20;                   // bytes in one key blob
    localparam int keyRot = 6;                      // left rotation of regrouped words

    localparam logic [7:0]  sumMask   = 8'hCF;      // byte bits that trigger the toggle
    localparam logic [11:0] sumToggle = 12'h065;    // xor pattern on the running sum

    // four round subkeys, subkey 0 in the low word
    typedef logic [3:0][15:0] keyWord;

    typedef struct packed {
        logic        valid;                         // slot carries a fetch
        logic [23:0] addr;                          // word address
        logic [15:0] data;                          // opcode word
    } fetchT;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;                           // register select
        logic [15:0] dat;                           // write data
    } wbReqT;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;                           // read data, valid with ack
    } wbRspT;

    typedef enum logic [1:0] {
        regData = 2'd0,                             // key byte write
        regSum  = 2'd1,                             // checksum read
        regStat = 2'd2                              // count/valid read, write clears
    } wbRegE;

endpackage

// ==== src/keyLoad.sv ====
// key loader with byte shift store, running checksum, byte count and key/range regrouping
module keyLoad
    import cryptPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        byteWe,            // one pulse per key byte
    input  logic [7:0]  keyByte,
    input  logic        clear,             // empties the loader
    output keyWord      key,
    output logic [15:0] addrRng,
    output logic [11:0] checksum,
    output logic [4:0]  count,
    output logic        keyValid
);

    localparam int storeBits = 8 * keyBytes;

    logic [storeBits-1:0] store;          // stream byte n ends at store byte n
    logic [11:0]          sumBase;        // sum after the optional toggle
    logic [11:0]          sumNext;
    logic                 countFull;

    // regrouped words are rotated left by keyRot
    function automatic logic [15:0] rotKey(input logic [15:0] w);
        return (w << keyRot) | (w >> (16 - keyRot));
    endfunction

    always_comb begin
        sumBase = ((keyByte & sumMask) != 8'd0) ? (checksum ^ sumToggle) : checksum;
        sumNext = sumBase + {{4{keyByte[7]}}, keyByte};  // sign extend, wraps at 12 bits
    end

    assign countFull = (count == 5'(keyBytes));
    assign keyValid  = countFull;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            store    <= '0;
            checksum <= '0;
            count    <= '0;
        end else if (clear) begin          // clear wins over a byte
            store    <= '0;
            checksum <= '0;
            count    <= '0;
        end else if (byteWe) begin
            store    <= {keyByte, store[storeBits-1:8]};  // enters at top, shifts down
            checksum <= sumNext;
            if (!countFull) begin
                count <= count + 5'd1;     // saturates at keyBytes
            end
        end
    end

    // subkey i from stream bytes 2i (low) and 2i+1 (high)
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            key[i] = rotKey(store[16*i +: 16]);
        end
    end

    assign addrRng = rotKey(store[storeBits-1 -: 16]);   // bytes 18 and 19

    // saturation must hold over any byte sequence
    countLimit: assert property (@(posedge clk) disable iff (rst) count <= 5'(keyBytes))
        else $error("key byte count above %0d", keyBytes);

endmodule

// ==== src/wbKeyPort.sv ====
// Wishbone classic slave decoding the key loader register map
module wbKeyPort
    import cryptPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  wbReqT       req,
    output wbRspT       rsp,
    output logic        byteWe,            // key byte strobe, ack cycle only
    output logic [7:0]  keyByte,
    output logic        clear,             // loader clear strobe
    input  logic [11:0] checksum,
    input  logic [4:0]  count,
    input  logic        keyValid
);

    logic  reqOn;                          // cycle and strobe both high
    logic  pending;                        // request already seen last cycle
    logic  ack;
    wbRegE regSel;

    assign reqOn  = req.cyc & req.stb;
    assign regSel = wbRegE'(req.adr);

    // ack once, one clock after the request first shows up
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            ack     <= 1'b0;
        end else begin
            pending <= reqOn;
            ack     <= reqOn & ~pending;
        end
    end

    always_comb begin
        rsp.ack = ack;
        rsp.dat = '0;
        if (ack && !req.we) begin
            case (regSel)
                regSum:  rsp.dat = {4'd0, checksum};
                regStat: rsp.dat = {keyValid, 10'd0, count};
                default: rsp.dat = '0;     // data register reads as zero
            endcase
        end
    end

    assign byteWe  = ack & req.we & (regSel == regData);
    assign clear   = ack & req.we & (regSel == regStat);
    assign keyByte = req.dat[7:0];

    // slave never acks outside a strobe
    ackInStb: assert property (@(posedge clk) disable iff (rst) rsp.ack |-> req.stb)
        else $error("ack without stb");

endmodule

// ==== src/feistelRound.sv ====
// one registered Feistel round of the opcode cipher
module feistelRound
    import cryptPkg::*;
#(
    parameter int Idx = 0                  // round index, picks the rotation
) (
    input  logic        clk,
    input  logic        rst,
    input  fetchT       in,
    input  logic [15:0] subkey,
    input  logic        bypass,            // slot passes untouched
    output fetchT       out
);

    localparam int rotAmt = (Idx % 4) + 1;

    logic [7:0]  halfL;                    // high byte
    logic [7:0]  halfR;                    // low byte
    logic [15:0] roundKey;                 // subkey mixed with address
    logic [7:0]  rotR;
    logic [7:0]  mixF;
    logic [15:0] wordNext;

    always_comb begin
        halfL    = in.data[15:8];
        halfR    = in.data[7:0];
        roundKey = subkey ^ in.addr[15:0];
        rotR     = (halfR << rotAmt) | (halfR >> (8 - rotAmt));
        mixF     = (rotR ^ roundKey[7:0]) + roundKey[15:8];  // mod 256
        wordNext = bypass ? in.data : {halfR, halfL ^ mixF};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out <= '0;
        end else begin
            out.valid <= in.valid;
            out.addr  <= in.addr;          // address travels with the slot
            out.data  <= wordNext;
        end
    end

endmodule

// ==== src/opDecrypt.sv ====
// pipelined opcode decryptor with range gating and valid pipeline
module opDecrypt
    import cryptPkg::*;
#(
    parameter int Rounds = 4               // pipeline depth, 1 to 8
) (
    input  logic        clk,
    input  logic        rst,
    input  keyWord      key,
    input  logic [15:0] addrRng,           // fetches below this decrypt
    input  logic        keyValid,
    input  fetchT       fin,
    output fetchT       fout
);

    fetchT stage [0:Rounds];               // stage i feeds round i
    logic  byp   [0:Rounds-1];             // bypass carried with each slot
    logic  inRange;

    // decision made once at entry
    assign inRange  = keyValid & (fin.addr[23:8] < addrRng);
    assign stage[0] = fin;
    assign byp[0]   = ~inRange;

    generate
        for (genvar i = 0; i < Rounds; i++) begin : gRound
            feistelRound #(
                .Idx    (i)
            ) uRound (
                .clk    (clk),
                .rst    (rst),
                .in     (stage[i]),
                .subkey (key[i % 4]),      // subkeys repeat every four rounds
                .bypass (byp[i]),
                .out    (stage[i+1])
            );

            if (i > 0) begin : gByp
                always_ff @(posedge clk) begin
                    byp[i] <= byp[i-1];    // follows the slot into round i
                end
            end
        end
    endgenerate

    assign fout = stage[Rounds];

    // each input slot shows up exactly Rounds cycles later
    validLatency: assert property (
        @(posedge clk) disable iff (rst) fout.valid == $past(fin.valid, Rounds)
    ) else $error("fetch valid lost or duplicated in the pipeline");

endmodule

// ==== src/cpsCrypt.sv ====
// top level joining the Wishbone key port, the key loader and the opcode decryptor
module cpsCrypt
    import cryptPkg::*;
#(
    parameter int Rounds = 4               // Feistel rounds in the fetch path
) (
    input  logic  clk,
    input  logic  rst,
    input  wbReqT wbReq,
    output wbRspT wbRsp,
    input  fetchT fetchIn,
    output fetchT fetchOut
);

    logic        byteWe;
    logic [7:0]  keyByte;
    logic        clear;
    logic [11:0] checksum;
    logic [4:0]  count;
    logic        keyValid;
    keyWord      key;
    logic [15:0] addrRng;

    wbKeyPort uPort (
        .clk      (clk),
        .rst      (rst),
        .req      (wbReq),
        .rsp      (wbRsp),
        .byteWe   (byteWe),
        .keyByte  (keyByte),
        .clear    (clear),
        .checksum (checksum),
        .count    (count),
        .keyValid (keyValid)
    );

    keyLoad uLoad (
        .clk      (clk),
        .rst      (rst),
        .byteWe   (byteWe),
        .keyByte  (keyByte),
        .clear    (clear),
        .key      (key),
        .addrRng  (addrRng),
        .checksum (checksum),
        .count    (count),
        .keyValid (keyValid)
    );

    opDecrypt #(
        .Rounds   (Rounds)
    ) uDecrypt (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .addrRng  (addrRng),
        .keyValid (keyValid),
        .fin      (fetchIn),
        .fout     (fetchOut)
    );

endmodule

// ==== dv/clkGen.sv ====
// testbench clock and reset generator
module clkGen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;            // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);         // reset held for 5 cycles
        #10 rst = 1'b0;
    end
endmodule

// ==== dv/cryptTb.sv ====
// directed testbench for cpsCrypt with reference model, compare tasks, scoreboard and timeout
module cryptTb
    import cryptPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int rounds = 4;
    localparam int maxCycles = 4000;        // tests need about 2500

    logic   clk;
    logic   rst;
    wbReqT  wbReq;
    wbRspT  wbRsp;
    fetchT  fetchIn;
    fetchT  fetchOut;
    integer seed = 32'h59e7_5b5c;
    int     cycles = 0;
    string  testName = "reset";
    fetchT  expQ[$];                        // expected slots in issue order
    int     dueQ[$];                        // cycle each slot must come out
    logic [7:0]  keyMem [0:19];             // model store, stream byte n at n
    logic [11:0] sumModel;
    logic [4:0]  byteCnt;

    clkGen uClk (.clk(clk), .rst(rst));

    cpsCrypt #(.Rounds(rounds)) UUT (
        .clk(clk), .rst(rst), .wbReq(wbReq), .wbRsp(wbRsp),
        .fetchIn(fetchIn), .fetchOut(fetchOut)
    );

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input string what, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp)
            failRun($sformatf("[ERROR] %s (%s): expected %h, actual %h", testName, what, exp, act));
    endtask

    task automatic checkFetch(input fetchT exp, input fetchT act);
        if (act !== exp)
            failRun($sformatf("[ERROR] %s (fetch): expected %h, actual %h", testName, exp, act));
    endtask

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    function automatic logic [15:0] rotWord(input logic [15:0] w);
        return {w[9:0], w[15:10]};          // rotate left by 6
    endfunction

    function automatic logic [15:0] modelRng();
        return rotWord({keyMem[19], keyMem[18]});
    endfunction

    // checksum step, shift store, saturating count
    task automatic modelByte(input logic [7:0] b);
        if ((b & 8'hCF) != 8'd0) sumModel = sumModel ^ 12'h065;
        sumModel = sumModel + {{4{b[7]}}, b};
        for (int n = 0; n < 19; n++) keyMem[n] = keyMem[n+1];
        keyMem[19] = b;
        if (byteCnt < 5'd20) byteCnt = byteCnt + 5'd1;
    endtask

    task automatic modelClear();
        for (int n = 0; n < 20; n++) keyMem[n] = 8'h00;
        sumModel = '0;
        byteCnt  = '0;
    endtask

    // four Feistel rounds when the key is full and the address is in range
    function automatic fetchT expectFetch(input fetchT f);
        fetchT e;
        logic [15:0] s;
        logic [7:0]  l;
        logic [7:0]  r;
        logic [7:0]  rr;
        logic [7:0]  fv;
        int          rot;
        e = f;
        if (byteCnt == 5'd20 && f.addr[23:8] < modelRng()) begin
            for (int k = 0; k < rounds; k++) begin
                l   = e.data[15:8];
                r   = e.data[7:0];
                s   = rotWord({keyMem[2*(k%4)+1], keyMem[2*(k%4)]}) ^ f.addr[15:0];
                rot = (k % 4) + 1;
                rr  = (r << rot) | (r >> (8 - rot));
                fv  = (rr ^ s[7:0]) + s[15:8];
                e.data = {r, l ^ fv};
            end
        end
        return e;
    endfunction

    function automatic fetchT makeFetch(input logic v, input logic [15:0] hi);
        fetchT f;
        logic [31:0] r;
        r = randWord();
        f.valid = v;
        f.addr  = {hi, r[23:16]};
        f.data  = r[15:0];
        return f;
    endfunction

    function automatic logic [15:0] inHi();
        logic [31:0] r;
        r = randWord();
        return 16'(r % {16'd0, modelRng()});
    endfunction

    function automatic logic [15:0] outHi();
        logic [31:0] r;
        logic [31:0] span;
        r = randWord();
        span = 32'd65536 - {16'd0, modelRng()};
        return modelRng() + 16'(r % span);
    endfunction

    // one Wishbone classic transfer, waits for ack
    task automatic wbXfer(input logic isWrite, input wbRegE adr, input logic [15:0] wdat,
                          output logic [15:0] rdat);
        @(posedge clk);
        #10;
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we  = isWrite;
        wbReq.adr = adr;
        wbReq.dat = wdat;
        @(negedge clk);
        while (wbRsp.ack !== 1'b1) @(negedge clk);
        rdat = wbRsp.dat;
        @(posedge clk);
        #10 wbReq = '0;                     // stb dropped after ack
    endtask

    task automatic checkRegs();
        logic [15:0] rd;
        wbXfer(1'b0, regSum, 16'h0000, rd);
        checkWord("regSum", {4'd0, sumModel}, rd);
        wbXfer(1'b0, regStat, 16'h0000, rd);
        checkWord("regStat", {byteCnt == 5'd20, 10'd0, byteCnt}, rd);
    endtask

    task automatic sendFetch(input fetchT f);
        @(posedge clk);
        #10 fetchIn = f;
        if (f.valid) begin
            expQ.push_back(expectFetch(f));
            dueQ.push_back(cycles + rounds);
        end
    endtask

    task automatic drainFetch();
        @(posedge clk);
        #10 fetchIn.valid = 1'b0;
        while (expQ.size() != 0) @(negedge clk);
    endtask

    task automatic loadKey();
        logic [15:0] rd;
        logic [31:0] r;
        logic [7:0]  b;
        testName = "keyLoad";
        for (int n = 0; n < 21; n++) begin
            r = randWord();
            b = (n == 20) ? ((r[7:0] & 8'hFC) | 8'h02) : r[7:0];  // range top bits 2'b10
            wbXfer(1'b1, regData, {8'h00, b}, rd);
            modelByte(b);
            checkRegs();
            if (n == 18) begin
                runFetches("partial", 40, 2);   // range is set, key one byte short
                testName = "keyLoad";
            end
        end
    endtask

    task automatic runFetches(input string name, input int num, input int mode);
        logic [31:0] r;
        testName = name;
        for (int n = 0; n < num; n++) begin
            r = randWord();
            if (mode == 0) sendFetch(makeFetch(1'b1, inHi()));
            else if (mode == 2) sendFetch(makeFetch(1'b1, r[31:16]));
            else if (r[1:0] == 2'd0) sendFetch(makeFetch(1'b0, r[31:16]));  // idle slot
            else if (r[1:0] == 2'd1) sendFetch(makeFetch(1'b1, outHi()));
            else sendFetch(makeFetch(1'b1, inHi()));
        end
        drainFetch();
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) failRun($sformatf("run did not finish in %0d cycles", maxCycles));
    end

    always @(negedge clk) begin
        fetchT exp;
        int    due;
        if (!rst && fetchOut.valid === 1'b1) begin
            if (expQ.size() == 0) begin
                failRun("a fetch came out while no fetch was outstanding");
            end else begin
                exp = expQ.pop_front();
                due = dueQ.pop_front();
                if (due != cycles)
                    failRun($sformatf("[ERROR] %s (latency): expected cycle %0d, actual %0d",
                                      testName, due, cycles));
                else
                    checkFetch(exp, fetchOut);
            end
        end
    end

    initial begin
        logic [15:0] rd;
        wbReq   = '0;
        fetchIn = '0;
        modelClear();
        wait (rst == 1'b0);
        checkRegs();                        // empty after reset
        runFetches("reset", 8, 2);
        loadKey();
        runFetches("inRange", 600, 0);
        runFetches("mixed", 1000, 1);
        testName = "clear";
        wbXfer(1'b1, regStat, 16'h0000, rd);
        modelClear();
        checkRegs();
        runFetches("clear", 400, 2);
        $display("TEST PASSED");
        $finish;
    end
endmodule

// ==== src.f ====
src/cryptPkg.sv
src/keyLoad.sv
src/wbKeyPort.sv
src/feistelRound.sv
src/opDecrypt.sv
src/cpsCrypt.sv
dv/clkGen.sv
dv/cryptTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the cpsCrypt testbench under Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cryptTb -f src.f -o cryptSim

./obj_dir/cryptSim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a pass line, see sim.log"
    exit 1
fi
echo "simulation passed"
